//--- ahb_addr_phase.sv
// AHB address stage that registers the request, decodes the windows and forms the byte strobe
`timescale 1ns/1ps

module ahb_addr_phase (
  input  logic                 bus_clk,
  input  logic                 rst_l,
  input  logic                 hsel,
  input  ahb_axi_pkg::addr_t   haddr,
  input  ahb_axi_pkg::hsize_t  hsize,
  input  logic                 hwrite,
  input  ahb_axi_pkg::htrans_t htrans,
  input  logic                 hready,
  ahb_req_if.req               req
);

  logic sample;
  logic in_dccm;
  logic in_iccm;
  logic tcm_access;
  logic bad_size;
  logic misaligned;

  ////////////////////
  // Phase registers
  ////////////////////

  // New address phase is taken only on a ready cycle with NONSEQ or SEQ
  assign sample = hready & hsel & htrans[1];

  // Live flag follows every ready cycle so idles clear it
  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      req.active_q <= 1'b0;
    end else if (hready) begin
      req.active_q <= hsel & htrans[1];
    end
  end

  // Payload holds across a stalled data phase
  always_ff @(posedge bus_clk) begin
    if (sample) begin
      req.haddr_q  <= haddr;
      req.hsize_q  <= hsize;
      req.hwrite_q <= hwrite;
    end
  end

  ////////////////////
  // Window decode
  ////////////////////

  // Each window spans 2**WIN_BITS bytes and matches on the upper bits
  assign in_dccm = (req.haddr_q[ahb_axi_pkg::ADDR_W-1:ahb_axi_pkg::WIN_BITS] ==
                    ahb_axi_pkg::DCCM_BASE[ahb_axi_pkg::ADDR_W-1:ahb_axi_pkg::WIN_BITS]);

  // ICCM can be compiled out through ICCM_EN
  assign in_iccm = ahb_axi_pkg::ICCM_EN &
                   (req.haddr_q[ahb_axi_pkg::ADDR_W-1:ahb_axi_pkg::WIN_BITS] ==
                    ahb_axi_pkg::ICCM_BASE[ahb_axi_pkg::ADDR_W-1:ahb_axi_pkg::WIN_BITS]);

  assign tcm_access = in_dccm | in_iccm;

  // ICCM accesses and DCCM writes must be word or doubleword
  // Sizes above doubleword never fit the 64-bit bus
  assign bad_size = ((in_iccm | (in_dccm & req.hwrite_q)) &
                     ~((req.hsize_q == ahb_axi_pkg::SIZE_WORD) |
                       (req.hsize_q == ahb_axi_pkg::SIZE_DWORD))) |
                    req.hsize_q[2];

  // Natural alignment per size
  assign misaligned = ((req.hsize_q == ahb_axi_pkg::SIZE_HALF)  &   req.haddr_q[0])   |
                      ((req.hsize_q == ahb_axi_pkg::SIZE_WORD)  & (|req.haddr_q[1:0])) |
                      ((req.hsize_q == ahb_axi_pkg::SIZE_DWORD) & (|req.haddr_q[2:0]));

  assign req.req_err = ~tcm_access | bad_size | misaligned;

  ////////////////////
  // Byte strobe
  ////////////////////

  // Lane mask shifted up by the byte offset and all lanes for a doubleword
  always_comb begin
    case (req.hsize_q[1:0])
      ahb_axi_pkg::SIZE_BYTE[1:0]: req.wstrb = ahb_axi_pkg::strb_t'(8'h01) << req.haddr_q[2:0];
      ahb_axi_pkg::SIZE_HALF[1:0]: req.wstrb = ahb_axi_pkg::strb_t'(8'h03) << req.haddr_q[2:0];
      ahb_axi_pkg::SIZE_WORD[1:0]: req.wstrb = ahb_axi_pkg::strb_t'(8'h0f) << req.haddr_q[2:0];
      default:                     req.wstrb = '1;
    endcase
  end

  // A legal data phase enables one lane per byte of its size, never zero lanes
  assert property (@(posedge bus_clk) disable iff (!rst_l)
    (req.active_q && !req.req_err) |-> ($countones(req.wstrb) == (1 << req.hsize_q)));

endmodule

//--- ahb_axi_pkg.sv
// Shared widths, address windows, bus types and transfer states of the AHB to AXI bridge
package ahb_axi_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  // One strobe bit per byte lane
  localparam int STRB_W = DATA_W / 8;

  // Any bus address
  typedef logic [ADDR_W-1:0] addr_t;
  // Write and read data
  typedef logic [DATA_W-1:0] data_t;
  // Byte lane enables
  typedef logic [STRB_W-1:0] strb_t;
  // AHB transfer size code
  typedef logic [2:0]        hsize_t;
  // AHB transfer type, bit 1 marks NONSEQ or SEQ
  typedef logic [1:0]        htrans_t;

  ////////////////////
  // Memory windows
  ////////////////////

  // Windows match on the bits above this one, 64 KB each
  localparam int    WIN_BITS  = 16;
  localparam addr_t DCCM_BASE = 32'hf004_0000;
  localparam addr_t ICCM_BASE = 32'hee00_0000;
  // Clear to remove the ICCM window
  localparam bit    ICCM_EN   = 1'b1;

  // hsize encodings
  localparam hsize_t SIZE_BYTE  = 3'd0;
  localparam hsize_t SIZE_HALF  = 3'd1;
  localparam hsize_t SIZE_WORD  = 3'd2;
  localparam hsize_t SIZE_DWORD = 3'd3;

  // Transfer machine
  typedef enum logic [1:0] {
    XFER_IDLE = 2'b00,  // No transfer in flight
    XFER_WR   = 2'b01,  // Write address phase taken, data phase now
    XFER_RD   = 2'b10,  // Read address phase taken, command not yet issued
    XFER_PEND = 2'b11   // Read issued, waiting on the R channel
  } xfer_state_t;

endpackage

//--- ahb_bridge_ctrl.sv
// Bridge control with the transfer machine, hreadyout and the two-cycle AHB error response
`timescale 1ns/1ps

module ahb_bridge_ctrl (
  input  logic                 bus_clk,
  input  logic                 rst_l,
  input  logic                 hsel,
  input  logic                 hwrite,
  input  ahb_axi_pkg::htrans_t htrans,
  input  logic                 hreadyin,
  output logic                 hreadyout,
  output logic                 hresp,
  output logic                 hready,
  input  logic                 r_valid,
  input  logic [1:0]           r_resp,
  ahb_req_if.ctrl              req,
  buf_ctl_if.ctrl              bctl
);

  ahb_axi_pkg::xfer_state_t state;
  ahb_axi_pkg::xfer_state_t state_nxt;
  logic                     state_en;

  // Registered copies for the second error cycle
  logic hresp_q;
  logic hready_q;

  logic req_bad;
  logic err_hold;
  logic rd_busy;

  ////////////////////
  // Transfer machine
  ////////////////////

  always_comb begin
    state_nxt       = ahb_axi_pkg::XFER_IDLE;
    state_en        = 1'b0;
    bctl.cmd_load   = 1'b0;
    bctl.rd_load    = 1'b0;
    bctl.rd_err_set = 1'b0;
    case (state)
      ahb_axi_pkg::XFER_IDLE: begin
        // Leave only on a taken address phase
        state_nxt = hwrite ? ahb_axi_pkg::XFER_WR : ahb_axi_pkg::XFER_RD;
        state_en  = hready & hsel & htrans[1];
      end
      ahb_axi_pkg::XFER_WR: begin
        // Data phase now and the next address phase may overlap it
        if (hresp || !hsel || !htrans[1]) begin
          state_nxt = ahb_axi_pkg::XFER_IDLE;
        end else begin
          state_nxt = hwrite ? ahb_axi_pkg::XFER_WR : ahb_axi_pkg::XFER_RD;
        end
        state_en      = ~bctl.cmd_full | hresp;
        // hwdata is valid now so load unless the transfer is illegal
        bctl.cmd_load = ~bctl.cmd_full & ~hresp;
      end
      ahb_axi_pkg::XFER_RD: begin
        // Bad reads return straight to idle
        state_nxt     = hresp ? ahb_axi_pkg::XFER_IDLE : ahb_axi_pkg::XFER_PEND;
        state_en      = ~bctl.cmd_full | hresp;
        bctl.cmd_load = ~bctl.cmd_full & ~hresp;
      end
      ahb_axi_pkg::XFER_PEND: begin
        // Stall until the read beat arrives
        state_nxt       = ahb_axi_pkg::XFER_IDLE;
        state_en        = r_valid & ~bctl.cmd_write;
        bctl.rd_load    = state_en;
        bctl.rd_err_set = state_en & (|r_resp);
      end
    endcase
  end

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      state <= ahb_axi_pkg::XFER_IDLE;
    end else if (state_en) begin
      state <= state_nxt;
    end
  end

  ////////////////////
  // AHB response
  ////////////////////

  // Illegal request seen in its data phase
  assign req_bad = req.active_q & (state != ahb_axi_pkg::XFER_IDLE) & req.req_err;

  // Second error cycle follows a stalled error cycle
  assign err_hold = hresp_q & ~hready_q;

  assign hresp = req_bad | bctl.rd_err | err_hold;

  // Reads hold the bus from issue until data is registered
  assign rd_busy = (state == ahb_axi_pkg::XFER_RD) | (state == ahb_axi_pkg::XFER_PEND);

  // Error drives low then high and other cycles wait on a full buffer or a read
  assign hreadyout = hresp ? err_hold :
                     ((~bctl.cmd_full | (state == ahb_axi_pkg::XFER_IDLE)) &
                      ~rd_busy & ~bctl.rd_err);

  assign hready = hreadyout & hreadyin;

  // Flush a pending read entry on error
  assign bctl.cmd_drop = hresp;

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      hresp_q  <= 1'b0;
      hready_q <= 1'b1;
    end else begin
      hresp_q  <= hresp;
      hready_q <= hready;
    end
  end

  // Each error response is one stalled cycle and one ready cycle and then ends
  assert property (@(posedge bus_clk) disable iff (!rst_l)
    (hresp && !hreadyout) |=> (hresp && hreadyout) ##1 !(hresp && hreadyout));

  // Only a live and legal data phase loads, and never over an entry still waiting
  assert property (@(posedge bus_clk) disable iff (!rst_l)
    bctl.cmd_load |-> (!bctl.cmd_full && req.active_q && !req.req_err));

endmodule

//--- ahb_req_if.sv
// Registered AHB address phase with its window decode, legality flag and byte strobe
`timescale 1ns/1ps

interface ahb_req_if;

  // Address phase fields, held through the data phase
  ahb_axi_pkg::addr_t  haddr_q;
  ahb_axi_pkg::hsize_t hsize_q;
  logic                hwrite_q;

  // Last sampled transfer was NONSEQ or SEQ with hsel high
  logic                active_q;

  // Outside both windows, wrong size or misaligned
  logic                req_err;

  // Byte lanes from size and low address bits
  ahb_axi_pkg::strb_t  wstrb;

  // Address stage drives everything
  modport req (
    output haddr_q,
    output hsize_q,
    output hwrite_q,
    output active_q,
    output req_err,
    output wstrb
  );

  // Control only needs to know if the data phase is live and legal
  modport ctrl (
    input active_q,
    input req_err
  );

  // Command buffer takes the payload
  modport cmd_buf (
    input haddr_q,
    input hsize_q,
    input hwrite_q,
    input wstrb
  );

endinterface

//--- ahb_to_axi_bridge.f
ahb_axi_pkg.sv
ahb_req_if.sv
buf_ctl_if.sv
ahb_addr_phase.sv
ahb_bridge_ctrl.sv
axi_cmd_buffer.sv
ahb_to_axi_bridge.sv
tb_axi_mem.sv
tb_ahb_to_axi_bridge.sv

//--- ahb_to_axi_bridge.sv
// AHB-Lite slave to AXI master bridge top connecting address stage, control and command buffer
`timescale 1ns/1ps

module ahb_to_axi_bridge (
  input  logic                 bus_clk,
  input  logic                 rst_l,
  // AHB-Lite slave
  input  logic                 hsel,
  input  ahb_axi_pkg::addr_t   haddr,
  input  ahb_axi_pkg::hsize_t  hsize,
  input  logic                 hwrite,
  input  ahb_axi_pkg::htrans_t htrans,
  input  ahb_axi_pkg::data_t   hwdata,
  input  logic                 hreadyin,
  output logic                 hreadyout,
  output logic                 hresp,
  output ahb_axi_pkg::data_t   hrdata,
  // AXI write address and data
  output ahb_axi_pkg::addr_t   aw_addr,
  output ahb_axi_pkg::hsize_t  aw_size,
  output logic                 aw_valid,
  input  logic                 aw_ready,
  output ahb_axi_pkg::data_t   w_data,
  output ahb_axi_pkg::strb_t   w_strb,
  output logic                 w_valid,
  // AXI read address and data
  output ahb_axi_pkg::addr_t   ar_addr,
  output ahb_axi_pkg::hsize_t  ar_size,
  output logic                 ar_valid,
  input  logic                 ar_ready,
  input  ahb_axi_pkg::data_t   r_data,
  input  logic [1:0]           r_resp,
  input  logic                 r_valid
);

  // Combined ready from control to the address stage
  logic hready;

  ahb_req_if req_if ();
  buf_ctl_if bctl_if ();

  ahb_addr_phase u_addr_phase (
    .bus_clk (bus_clk),
    .rst_l   (rst_l),
    .hsel    (hsel),
    .haddr   (haddr),
    .hsize   (hsize),
    .hwrite  (hwrite),
    .htrans  (htrans),
    .hready  (hready),
    .req     (req_if)
  );

  ahb_bridge_ctrl u_ctrl (
    .bus_clk   (bus_clk),
    .rst_l     (rst_l),
    .hsel      (hsel),
    .hwrite    (hwrite),
    .htrans    (htrans),
    .hreadyin  (hreadyin),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .hready    (hready),
    .r_valid   (r_valid),
    .r_resp    (r_resp),
    .req       (req_if),
    .bctl      (bctl_if)
  );

  axi_cmd_buffer u_cmd_buffer (
    .bus_clk  (bus_clk),
    .rst_l    (rst_l),
    .hwdata   (hwdata),
    .req      (req_if),
    .bctl     (bctl_if),
    .aw_addr  (aw_addr),
    .aw_size  (aw_size),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w_data   (w_data),
    .w_strb   (w_strb),
    .w_valid  (w_valid),
    .ar_addr  (ar_addr),
    .ar_size  (ar_size),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r_data   (r_data),
    .hrdata   (hrdata)
  );

endmodule

//--- axi_cmd_buffer.sv
// One-entry command buffer that issues single-beat AXI requests and holds the read return
`timescale 1ns/1ps

module axi_cmd_buffer (
  input  logic                 bus_clk,
  input  logic                 rst_l,
  input  ahb_axi_pkg::data_t   hwdata,
  ahb_req_if.cmd_buf           req,
  buf_ctl_if.cmd_buf           bctl,
  // AW channel
  output ahb_axi_pkg::addr_t   aw_addr,
  output ahb_axi_pkg::hsize_t  aw_size,
  output logic                 aw_valid,
  input  logic                 aw_ready,
  // W channel
  output ahb_axi_pkg::data_t   w_data,
  output ahb_axi_pkg::strb_t   w_strb,
  output logic                 w_valid,
  // AR channel
  output ahb_axi_pkg::addr_t   ar_addr,
  output ahb_axi_pkg::hsize_t  ar_size,
  output logic                 ar_valid,
  input  logic                 ar_ready,
  // R data and the AHB side copy
  input  ahb_axi_pkg::data_t   r_data,
  output ahb_axi_pkg::data_t   hrdata
);

  // Entry
  logic                cmd_vld;
  logic                cmd_wr;
  ahb_axi_pkg::hsize_t cmd_size;
  ahb_axi_pkg::addr_t  cmd_addr;
  ahb_axi_pkg::strb_t  cmd_strb;
  ahb_axi_pkg::data_t  cmd_data;

  // Read return
  ahb_axi_pkg::data_t  rdata_q;

  logic cmd_sent;
  logic cmd_clr;

  ////////////////////
  // Entry control
  ////////////////////

  // Either address handshake retires the entry
  assign cmd_sent = (aw_valid & aw_ready) | (ar_valid & ar_ready);

  // Back-to-back load keeps it valid; writes are never flushed
  assign cmd_clr = (cmd_sent & ~bctl.cmd_load) | (bctl.cmd_drop & ~cmd_wr);

  assign bctl.cmd_full  = cmd_vld & ~cmd_sent;
  assign bctl.cmd_write = cmd_wr;

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      cmd_vld     <= 1'b0;
      cmd_wr      <= 1'b0;
      bctl.rd_err <= 1'b0;
    end else begin
      if (cmd_clr) begin
        cmd_vld <= 1'b0;
      end else if (bctl.cmd_load) begin
        cmd_vld <= 1'b1;
      end
      if (bctl.cmd_load) begin
        cmd_wr <= req.hwrite_q;
      end
      // Single-cycle flag, the control turns it into hresp
      bctl.rd_err <= bctl.rd_err_set;
    end
  end

  // Payload from the address stage, data straight off the AHB data phase
  always_ff @(posedge bus_clk) begin
    if (bctl.cmd_load) begin
      cmd_size <= req.hsize_q;
      cmd_addr <= req.haddr_q;
      cmd_strb <= req.wstrb;
      cmd_data <= hwdata;
    end
    if (bctl.rd_load) begin
      rdata_q <= r_data;
    end
  end

  ////////////////////
  // AXI request
  ////////////////////

  // Address and data go out together, released on aw_ready
  assign aw_addr  = cmd_addr;
  assign aw_size  = cmd_size;
  assign aw_valid = cmd_vld & cmd_wr;

  assign w_data  = cmd_data;
  assign w_strb  = cmd_strb;
  assign w_valid = aw_valid;

  assign ar_addr  = cmd_addr;
  assign ar_size  = cmd_size;
  assign ar_valid = cmd_vld & ~cmd_wr;

  assign hrdata = rdata_q;

  // Write request holds its address while the slave stalls
  assert property (@(posedge bus_clk) disable iff (!rst_l)
    (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw_addr)));

endmodule

//--- buf_ctl_if.sv
// Load, release and status signals between the bridge control and the command buffer
`timescale 1ns/1ps

interface buf_ctl_if;

  // From control
  logic cmd_load;    // One-cycle strobe, capture the entry
  logic cmd_drop;    // Error response, flush a read entry
  logic rd_load;     // Capture r_data
  logic rd_err_set;  // Read came back with a nonzero r_resp

  // From buffer
  logic cmd_full;    // Entry valid and not leaving this cycle
  logic cmd_write;   // Direction of the stored entry
  logic rd_err;      // Registered read error, one cycle

  modport ctrl (
    output cmd_load,
    output cmd_drop,
    output rd_load,
    output rd_err_set,
    input  cmd_full,
    input  cmd_write,
    input  rd_err
  );

  modport cmd_buf (
    input  cmd_load,
    input  cmd_drop,
    input  rd_load,
    input  rd_err_set,
    output cmd_full,
    output cmd_write,
    output rd_err
  );

endinterface

//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ahb_to_axi_bridge \
  -f ahb_to_axi_bridge.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

//--- tb_ahb_to_axi_bridge.sv
// Testbench for the AHB to AXI bridge with an AHB master, AXI memory model and checks
`timescale 1ns/1ps

module tb_ahb_to_axi_bridge;

  localparam int TIMEOUT = 200;
  localparam ahb_axi_pkg::addr_t DCCM = ahb_axi_pkg::DCCM_BASE;

  logic                 bus_clk;
  logic                 rst_l;
  logic                 hsel;
  ahb_axi_pkg::addr_t   haddr;
  ahb_axi_pkg::hsize_t  hsize;
  logic                 hwrite;
  ahb_axi_pkg::htrans_t htrans;
  ahb_axi_pkg::data_t   hwdata;
  logic                 hreadyout;
  logic                 hresp;
  ahb_axi_pkg::data_t   hrdata;
  ahb_axi_pkg::addr_t   aw_addr;
  ahb_axi_pkg::hsize_t  aw_size;
  logic                 aw_valid;
  logic                 aw_ready;
  ahb_axi_pkg::data_t   w_data;
  ahb_axi_pkg::strb_t   w_strb;
  logic                 w_valid;
  ahb_axi_pkg::addr_t   ar_addr;
  ahb_axi_pkg::hsize_t  ar_size;
  logic                 ar_valid;
  logic                 ar_ready;
  ahb_axi_pkg::data_t   r_data;
  logic [1:0]           r_resp;
  logic                 r_valid;
  int                   aw_stall;

  int                   errors;
  int                   exp_aw;
  int                   exp_ar;
  int                   ar_cnt;
  ahb_axi_pkg::data_t   shadow [256];

  // Logged AW handshakes in arrival order
  ahb_axi_pkg::addr_t   aw_log_addr [$];
  ahb_axi_pkg::hsize_t  aw_log_size [$];
  ahb_axi_pkg::data_t   aw_log_data [$];
  ahb_axi_pkg::strb_t   aw_log_strb [$];

  // Logged AR handshakes in arrival order
  ahb_axi_pkg::addr_t   ar_log_addr [$];
  ahb_axi_pkg::hsize_t  ar_log_size [$];

  ahb_to_axi_bridge uut (
    .bus_clk (bus_clk), .rst_l (rst_l),
    .hsel (hsel), .haddr (haddr), .hsize (hsize), .hwrite (hwrite), .htrans (htrans),
    .hwdata (hwdata), .hreadyin (hreadyout), .hreadyout (hreadyout), .hresp (hresp),
    .hrdata (hrdata),
    .aw_addr (aw_addr), .aw_size (aw_size), .aw_valid (aw_valid), .aw_ready (aw_ready),
    .w_data (w_data), .w_strb (w_strb), .w_valid (w_valid),
    .ar_addr (ar_addr), .ar_size (ar_size), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r_data (r_data), .r_resp (r_resp), .r_valid (r_valid)
  );

  tb_axi_mem u_mem (
    .bus_clk (bus_clk), .rst_l (rst_l),
    .aw_addr (aw_addr), .aw_valid (aw_valid), .aw_ready (aw_ready),
    .w_data (w_data), .w_strb (w_strb), .w_valid (w_valid),
    .ar_addr (ar_addr), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r_data (r_data), .r_resp (r_resp), .r_valid (r_valid),
    .aw_stall (aw_stall), .err_addr (DCCM + 32'h100)
  );

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;
  end

  ////////////////////
  // Monitors
  ////////////////////

  always @(posedge bus_clk) begin
    if (rst_l && aw_valid && aw_ready) begin
      aw_log_addr.push_back(aw_addr);
      aw_log_size.push_back(aw_size);
      aw_log_data.push_back(w_data);
      aw_log_strb.push_back(w_strb);
    end
    if (rst_l && ar_valid && ar_ready) begin
      ar_cnt++;
      ar_log_addr.push_back(ar_addr);
      ar_log_size.push_back(ar_size);
    end
  end

  // Write data always travels with the write address
  assert property (@(posedge bus_clk) disable iff (!rst_l) w_valid == aw_valid)
    else log_mismatch("w_valid differs from aw_valid");

  ////////////////////
  // Helpers
  ////////////////////

  task automatic log_mismatch(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failed");
    $finish;
  endtask

  // Byte lanes cover 2**size bytes from the offset inside the doubleword
  function automatic ahb_axi_pkg::strb_t lane_mask(input ahb_axi_pkg::hsize_t s,
                                                    input ahb_axi_pkg::addr_t a);
    int nbytes;
    nbytes = 1 << s;
    return ahb_axi_pkg::strb_t'(((1 << nbytes) - 1) << a[2:0]);
  endfunction

  task automatic addr_phase(input ahb_axi_pkg::addr_t a, input ahb_axi_pkg::hsize_t s,
                            input logic w);
    hsel   = 1'b1;
    haddr  = a;
    hsize  = s;
    hwrite = w;
    htrans = 2'b10;
    @(posedge bus_clk);
    #2;
    hsel   = 1'b0;
    htrans = 2'b00;
  endtask

  // Data phase ends on the edge after hreadyout is seen high
  task automatic wait_ready(output ahb_axi_pkg::data_t rd, output int lows);
    logic seen;
    seen = 1'b0;
    lows = 0;
    while (!seen) begin
      @(negedge bus_clk);
      if (hreadyout) begin
        seen = 1'b1;
      end else begin
        lows++;
        if (lows > TIMEOUT) abort_run("hreadyout");
      end
    end
    assert (!hresp) else log_mismatch("unexpected hresp on a legal transfer");
    rd = hrdata;
    @(posedge bus_clk);
    #2;
  endtask

  // Two-cycle error with hreadyout low and then high before hresp drops
  task automatic expect_error();
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge bus_clk);
      if (hresp) begin
        seen = 1'b1;
      end else if (hreadyout) begin
        log_mismatch("transfer completed without hresp");
        return;
      end else begin
        n++;
        if (n > TIMEOUT) abort_run("hresp");
      end
    end
    assert (!hreadyout) else log_mismatch("hreadyout high in first error cycle");
    @(negedge bus_clk);
    assert (hresp && hreadyout) else log_mismatch("second error cycle wrong");
    @(posedge bus_clk);
    #2;
    @(negedge bus_clk);
    assert (!hresp) else log_mismatch("hresp longer than two cycles");
    @(posedge bus_clk);
    #2;
  endtask

  task automatic wait_aw(input int n);
    int t;
    t = 0;
    while (aw_log_addr.size() < n) begin
      @(negedge bus_clk);
      t++;
      if (t > TIMEOUT) abort_run("AW handshake");
    end
  endtask

  // Compare logged AW k against the request and update the shadow memory
  task automatic check_aw(input int k, input ahb_axi_pkg::addr_t a,
                          input ahb_axi_pkg::hsize_t s, input ahb_axi_pkg::data_t d);
    ahb_axi_pkg::strb_t m;
    m = lane_mask(s, a);
    assert (aw_log_addr[k] == a) else log_mismatch($sformatf("aw_addr %h", aw_log_addr[k]));
    assert (aw_log_size[k] == s) else log_mismatch($sformatf("aw_size %0d", aw_log_size[k]));
    assert (aw_log_data[k] == d) else log_mismatch($sformatf("w_data %h", aw_log_data[k]));
    assert (aw_log_strb[k] == m) else log_mismatch($sformatf("w_strb %h", aw_log_strb[k]));
    for (int i = 0; i < 8; i++) begin
      if (m[i]) shadow[a[10:3]][8*i +: 8] = d[8*i +: 8];
    end
  endtask

  task automatic ahb_write(input ahb_axi_pkg::addr_t a, input ahb_axi_pkg::hsize_t s,
                           input ahb_axi_pkg::data_t d);
    ahb_axi_pkg::data_t rd;
    int lows;
    int k;
    k = aw_log_addr.size();
    addr_phase(a, s, 1'b1);
    hwdata = d;
    wait_ready(rd, lows);
    exp_aw++;
    wait_aw(k + 1);
    check_aw(k, a, s, d);
  endtask

  task automatic ahb_read(input ahb_axi_pkg::addr_t a, input ahb_axi_pkg::hsize_t s);
    ahb_axi_pkg::data_t rd;
    int lows;
    int k;
    k = ar_log_addr.size();
    addr_phase(a, s, 1'b0);
    wait_ready(rd, lows);
    exp_ar++;
    assert (rd == shadow[a[10:3]])
      else log_mismatch($sformatf("hrdata %h expected %h", rd, shadow[a[10:3]]));
    // The AR request is taken before the read data returns
    assert (ar_log_addr.size() == k + 1) else log_mismatch("read gave no single AR request");
    if (ar_log_addr.size() > k) begin
      assert (ar_log_addr[k] == a) else log_mismatch($sformatf("ar_addr %h", ar_log_addr[k]));
      assert (ar_log_size[k] == s) else log_mismatch($sformatf("ar_size %0d", ar_log_size[k]));
    end
  endtask

  task automatic ahb_bad(input ahb_axi_pkg::addr_t a, input ahb_axi_pkg::hsize_t s,
                         input logic w);
    int aw0;
    int ar0;
    aw0 = aw_log_addr.size();
    ar0 = ar_cnt;
    addr_phase(a, s, w);
    hwdata = 64'hbad0_bad0_bad0_bad0;
    expect_error();
    assert (aw_log_addr.size() == aw0 && ar_cnt == ar0)
      else log_mismatch("AXI request after an illegal transfer");
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    ahb_axi_pkg::data_t rd;
    int lows;
    int k;
    rst_l = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    hsize = '0;
    hwrite = 1'b0;
    htrans = 2'b00;
    hwdata = '0;
    aw_stall = 0;
    errors = 0;
    exp_aw = 0;
    exp_ar = 0;
    ar_cnt = 0;
    for (int i = 0; i < 256; i++) shadow[i] = '0;
    repeat (4) @(posedge bus_clk);
    #2;
    rst_l = 1'b1;

    // Idle outputs after reset
    @(negedge bus_clk);
    assert (hreadyout && !hresp && !aw_valid && !ar_valid)
      else log_mismatch("outputs not idle after reset");
    @(posedge bus_clk);
    #2;

    ahb_write(DCCM + 32'h4, ahb_axi_pkg::SIZE_WORD, 64'h1111_2222_3333_4444);
    ahb_write(DCCM + 32'h8, ahb_axi_pkg::SIZE_DWORD, 64'h0123_4567_89ab_cdef);

    ahb_read(DCCM + 32'h0, ahb_axi_pkg::SIZE_DWORD);
    ahb_read(DCCM + 32'h4, ahb_axi_pkg::SIZE_WORD);
    ahb_read(DCCM + 32'ha, ahb_axi_pkg::SIZE_HALF);
    ahb_read(DCCM + 32'hd, ahb_axi_pkg::SIZE_BYTE);

    ahb_bad(32'h1000_0000, ahb_axi_pkg::SIZE_WORD, 1'b0);
    ahb_bad(DCCM + 32'h11, ahb_axi_pkg::SIZE_BYTE, 1'b1);
    ahb_bad(ahb_axi_pkg::ICCM_BASE + 32'h10, ahb_axi_pkg::SIZE_HALF, 1'b0);
    ahb_bad(DCCM + 32'h22, ahb_axi_pkg::SIZE_WORD, 1'b0);

    // Read error from the marked address
    addr_phase(DCCM + 32'h100, ahb_axi_pkg::SIZE_WORD, 1'b0);
    exp_ar++;
    expect_error();

    // Second write waits on the stalled first one
    aw_stall = 6;
    k = aw_log_addr.size();
    addr_phase(DCCM + 32'h40, ahb_axi_pkg::SIZE_DWORD, 1'b1);
    hwdata = 64'haaaa_bbbb_cccc_dddd;
    wait_ready(rd, lows);
    addr_phase(DCCM + 32'h44, ahb_axi_pkg::SIZE_WORD, 1'b1);
    hwdata = 64'h5555_6666_7777_8888;
    wait_ready(rd, lows);
    assert (lows > 0) else log_mismatch("hreadyout not held low during AW stall");
    exp_aw += 2;
    wait_aw(k + 2);
    aw_stall = 0;
    check_aw(k, DCCM + 32'h40, ahb_axi_pkg::SIZE_DWORD, 64'haaaa_bbbb_cccc_dddd);
    check_aw(k + 1, DCCM + 32'h44, ahb_axi_pkg::SIZE_WORD, 64'h5555_6666_7777_8888);
    ahb_read(DCCM + 32'h40, ahb_axi_pkg::SIZE_DWORD);

    assert (aw_log_addr.size() == exp_aw) else log_mismatch("AW request count wrong");
    assert (ar_cnt == exp_ar) else log_mismatch("AR request count wrong");

    $display("Checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb_axi_mem.sv
// Behavioral AXI slave memory with write-address stalls, random read latency and one error address
`timescale 1ns/1ps

module tb_axi_mem (
  input  logic                bus_clk,
  input  logic                rst_l,
  input  ahb_axi_pkg::addr_t  aw_addr,
  input  logic                aw_valid,
  output logic                aw_ready,
  input  ahb_axi_pkg::data_t  w_data,
  input  ahb_axi_pkg::strb_t  w_strb,
  input  logic                w_valid,
  input  ahb_axi_pkg::addr_t  ar_addr,
  input  logic                ar_valid,
  output logic                ar_ready,
  output ahb_axi_pkg::data_t  r_data,
  output logic [1:0]          r_resp,
  output logic                r_valid,
  input  int                  aw_stall,
  input  ahb_axi_pkg::addr_t  err_addr
);

  // 256 doublewords, indexed by address bits 10 to 3
  ahb_axi_pkg::data_t mem [256];
  integer             seed;
  int                 stall_cnt;
  logic               rd_busy;
  logic [2:0]         rd_wait;
  ahb_axi_pkg::addr_t rd_addr;

  initial begin
    seed = 32'h9b09_db72;
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
  end

  ////////////////////
  // Write side
  ////////////////////

  // aw_ready held low for aw_stall cycles of a pending aw_valid
  assign aw_ready = aw_valid && (stall_cnt >= aw_stall);

  always @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      stall_cnt <= 0;
    end else if (aw_valid && !aw_ready) begin
      stall_cnt <= stall_cnt + 1;
    end else begin
      stall_cnt <= 0;
    end
  end

  // Data is taken together with the address
  always @(posedge bus_clk) begin
    if (aw_valid && aw_ready && w_valid) begin
      for (int i = 0; i < 8; i++) begin
        if (w_strb[i]) begin
          mem[aw_addr[10:3]][8*i +: 8] <= w_data[8*i +: 8];
        end
      end
    end
  end

  ////////////////////
  // Read side
  ////////////////////

  assign ar_ready = !rd_busy;

  // One read at a time, answered after 1 to 4 cycles
  always @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      rd_busy <= 1'b0;
      rd_wait <= 3'd0;
      rd_addr <= '0;
      r_valid <= 1'b0;
      r_resp  <= 2'b00;
      r_data  <= '0;
    end else begin
      r_valid <= 1'b0;
      if (ar_valid && ar_ready) begin
        rd_busy <= 1'b1;
        rd_addr <= ar_addr;
        rd_wait <= 3'(1 + ($random(seed) & 3));
      end else if (rd_busy) begin
        if (rd_wait == 3'd1) begin
          rd_busy <= 1'b0;
          r_valid <= 1'b1;
          r_data  <= mem[rd_addr[10:3]];
          // SLVERR on the marked address
          r_resp  <= (rd_addr == err_addr) ? 2'b10 : 2'b00;
        end else begin
          rd_wait <= rd_wait - 3'd1;
        end
      end
    end
  end

endmodule
